/* Bender.yml */
package:
  name: rv_decode_stage

sources:
  - files:
      - source/rv_decode_pkg.sv
      - source/inst_decoder.sv
      - source/imm_gen.sv
      - source/operand_forward.sv
      - source/id_ex_reg.sv
      - source/decode_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_decode_stage.sv

/* bench/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

localparam int NUM_VEC = 17;

// where an operand is expected to come from
typedef enum logic [1:0] {SRC_REG, SRC_EX, SRC_MEM} src_e;

typedef struct packed {
  logic [31:0] inst;
  reg_idx_t    mem_rd;
  src_e        src1;
  src_e        src2;
  logic        load_use;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  reg_idx_t    rd;
  xlen_t       imm;
  csr_idx_t    csr_idx;
  logic        csr_imm_valid;
  logic [4:0]  csr_imm;
  alu_op_e     alu_op;
  exc_op_e     exc_op;
  mem_op_e     mem_op;
  csr_op_e     csr_op;
  logic [3:0]  trap;
} vec_t;

vec_t vec [NUM_VEC];

// the columns are instruction, MEM rd, rs1 source, rs2 source, load-use, rs1 index,
// rs2 index, then ex rd, immediate, CSR index, CSR imm valid, CSR imm, ALU, class,
// mem, CSR and traps
function automatic void fill_vectors();
  // addi x5, x1, -3
  vec[0]  = '{32'hffd08293, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd1, 5'd0, 5'd5,
    64'hfffffffffffffffd, 12'h000, 1'b0, 5'd0, ALU_ADD, EXC_OPIMM, MEM_NOP, CSR_NOP, 4'b0000};
  // sw x5, 8(x2) with x2 in MEM and x5 in EX
  vec[1]  = '{32'h00512423, 5'd2, SRC_MEM, SRC_EX, 1'b0, 5'd2, 5'd5, 5'd0,
    64'h8, 12'h000, 1'b0, 5'd0, ALU_ADD, EXC_STORE, MEM_SW, CSR_NOP, 4'b0000};
  // beq x1, x3, -16
  vec[2]  = '{32'hfe3088e3, 5'd3, SRC_REG, SRC_MEM, 1'b0, 5'd1, 5'd3, 5'd0,
    64'hfffffffffffffff0, 12'h000, 1'b0, 5'd0, ALU_BEQ, EXC_BRANCH, MEM_NOP, CSR_NOP, 4'b0000};
  // lui x7, 0x80001
  vec[3]  = '{32'h800013b7, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd7,
    64'hffffffff80001000, 12'h000, 1'b0, 5'd0, ALU_ADD, EXC_LUI, MEM_NOP, CSR_NOP, 4'b0000};
  // jal x1, -4
  vec[4]  = '{32'hffdff0ef, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd1,
    64'hfffffffffffffffc, 12'h000, 1'b0, 5'd0, ALU_ADD, EXC_JAL, MEM_NOP, CSR_NOP, 4'b0000};
  // add x8, x1, x7 with x1 in both EX and MEM
  vec[5]  = '{32'h00708433, 5'd1, SRC_EX, SRC_REG, 1'b0, 5'd1, 5'd7, 5'd8,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_ADD, EXC_OP, MEM_NOP, CSR_NOP, 4'b0000};
  // mulw x9, x8, x0 while MEM reports x0
  vec[6]  = '{32'h020404bb, 5'd0, SRC_EX, SRC_REG, 1'b0, 5'd8, 5'd0, 5'd9,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_MULW, EXC_OP32, MEM_NOP, CSR_NOP, 4'b0000};
  // ld x10, 16(x9)
  vec[7]  = '{32'h0104b503, 5'd0, SRC_EX, SRC_REG, 1'b0, 5'd9, 5'd0, 5'd10,
    64'h10, 12'h000, 1'b0, 5'd0, ALU_ADD, EXC_LOAD, MEM_LD, CSR_NOP, 4'b0000};
  // add x11, x10, x2 right behind the load stalls
  vec[8]  = '{32'h002505b3, 5'd0, SRC_EX, SRC_REG, 1'b1, 5'd10, 5'd2, 5'd0,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_NOP, EXC_BUBBLE, MEM_NOP, CSR_NOP, 4'b0000};
  // repeated with the load data now in MEM
  vec[9]  = '{32'h002505b3, 5'd10, SRC_MEM, SRC_REG, 1'b0, 5'd10, 5'd2, 5'd11,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_ADD, EXC_OP, MEM_NOP, CSR_NOP, 4'b0000};
  // csrrw x12, 0x300, x11
  vec[10] = '{32'h30059673, 5'd0, SRC_EX, SRC_REG, 1'b0, 5'd11, 5'd0, 5'd12,
    64'h300, 12'h300, 1'b0, 5'd0, ALU_ADD, EXC_CSR, MEM_NOP, CSR_WRITE, 4'b0000};
  // csrrs x13, 0x341, x0
  vec[11] = '{32'h341026f3, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd13,
    64'h341, 12'h341, 1'b0, 5'd0, ALU_ADD, EXC_CSR, MEM_NOP, CSR_READ, 4'b0000};
  // csrrci x14, 0x304, 5
  vec[12] = '{32'h3042f773, 5'd5, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd14,
    64'h304, 12'h304, 1'b1, 5'd5, ALU_ADD, EXC_CSR, MEM_NOP, CSR_CLEAR, 4'b0000};
  // ecall, ebreak, mret, then an unused opcode
  vec[13] = '{32'h00000073, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd0,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_NOP, EXC_BUBBLE, MEM_NOP, CSR_NOP, 4'b0001};
  vec[14] = '{32'h00100073, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd0,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_NOP, EXC_EBREAK, MEM_NOP, CSR_NOP, 4'b0010};
  vec[15] = '{32'h30200073, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd0,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_NOP, EXC_BUBBLE, MEM_NOP, CSR_NOP, 4'b0100};
  vec[16] = '{32'h0000007f, 5'd0, SRC_REG, SRC_REG, 1'b0, 5'd0, 5'd0, 5'd0,
    64'h0, 12'h000, 1'b0, 5'd0, ALU_NOP, EXC_NONE, MEM_NOP, CSR_NOP, 4'b1000};
endfunction

`endif

/* bench/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;
  import rv_decode_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 4;

  `include "decode_vectors.svh"

  // four clock periods per row plus reset and release
  localparam int TIMEOUT_NS = NUM_VEC * CLK_PERIOD * 4 + (RST_CYCLES + 1) * CLK_PERIOD;

  logic                 clk;
  logic                 rst_n;
  xlen_t                inst_addr;
  logic [INST_W-1:0]    inst_data;
  xlen_t                rs1_data;
  xlen_t                rs2_data;
  xlen_t                ex_rd_data;
  reg_idx_t             mem_rd_addr;
  xlen_t                mem_rd_data;
  reg_idx_t             rs1_idx;
  reg_idx_t             rs2_idx;
  logic                 load_use;
  xlen_t                ex_inst_addr;
  xlen_t                ex_rs1_data;
  xlen_t                ex_rs2_data;
  reg_idx_t             ex_rd_idx;
  xlen_t                ex_imm;
  csr_idx_t             ex_csr_idx;
  logic [CSR_IMM_W-1:0] ex_csr_imm;
  logic                 ex_csr_imm_valid;
  alu_op_e              ex_alu_op;
  exc_op_e              ex_exc_op;
  mem_op_e              ex_mem_op;
  csr_op_e              ex_csr_op;
  logic [TRAP_W-1:0]    ex_trap;

  integer seed = 32'hde10;
  xlen_t  pc;
  xlen_t  exp_rs1;
  xlen_t  exp_rs2;

  decode_stage u_dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .inst_addr_i        (inst_addr),
    .inst_data_i        (inst_data),
    .rs1_data_i         (rs1_data),
    .rs2_data_i         (rs2_data),
    .ex_rd_data_i       (ex_rd_data),
    .mem_rd_addr_i      (mem_rd_addr),
    .mem_rd_data_i      (mem_rd_data),
    .rs1_idx_o          (rs1_idx),
    .rs2_idx_o          (rs2_idx),
    .load_use_o         (load_use),
    .ex_inst_addr_o     (ex_inst_addr),
    .ex_rs1_data_o      (ex_rs1_data),
    .ex_rs2_data_o      (ex_rs2_data),
    .ex_rd_idx_o        (ex_rd_idx),
    .ex_imm_o           (ex_imm),
    .ex_csr_idx_o       (ex_csr_idx),
    .ex_csr_imm_o       (ex_csr_imm),
    .ex_csr_imm_valid_o (ex_csr_imm_valid),
    .ex_alu_op_o        (ex_alu_op),
    .ex_exc_op_o        (ex_exc_op),
    .ex_mem_op_o        (ex_mem_op),
    .ex_csr_op_o        (ex_csr_op),
    .ex_trap_o          (ex_trap)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic xlen_t pick_operand(src_e src, xlen_t rf_word, xlen_t ex_word,
                                         xlen_t mem_word);
    case (src)
      SRC_EX:  return ex_word;
      SRC_MEM: return mem_word;
      default: return rf_word;
    endcase
  endfunction

  task automatic expect_bubble();
    compare_value("ex_exc_op_o", ex_exc_op, EXC_BUBBLE);
    compare_value("ex_alu_op_o", ex_alu_op, ALU_NOP);
    compare_value("ex_mem_op_o", ex_mem_op, MEM_NOP);
    compare_value("ex_csr_op_o", ex_csr_op, CSR_NOP);
    compare_value("ex_trap_o", ex_trap, '0);
    compare_value("ex_rd_idx_o", ex_rd_idx, '0);
    compare_value("ex_csr_imm_valid_o", ex_csr_imm_valid, 1'b0);
  endtask

  task automatic verify_row(input int row, input xlen_t row_pc, input xlen_t rs1_word,
                            input xlen_t rs2_word);
    compare_value("ex_rd_idx_o", ex_rd_idx, vec[row].rd);
    compare_value("ex_csr_imm_valid_o", ex_csr_imm_valid, vec[row].csr_imm_valid);
    compare_value("ex_alu_op_o", ex_alu_op, vec[row].alu_op);
    compare_value("ex_exc_op_o", ex_exc_op, vec[row].exc_op);
    compare_value("ex_mem_op_o", ex_mem_op, vec[row].mem_op);
    compare_value("ex_csr_op_o", ex_csr_op, vec[row].csr_op);
    compare_value("ex_trap_o", ex_trap, vec[row].trap);
    // a stalled row leaves a bubble whose payload carries nothing
    if (!vec[row].load_use) begin
      compare_value("ex_inst_addr_o", ex_inst_addr, row_pc);
      compare_value("ex_rs1_data_o", ex_rs1_data, rs1_word);
      compare_value("ex_rs2_data_o", ex_rs2_data, rs2_word);
      compare_value("ex_imm_o", ex_imm, vec[row].imm);
      compare_value("ex_csr_idx_o", ex_csr_idx, vec[row].csr_idx);
      compare_value("ex_csr_imm_o", ex_csr_imm, vec[row].csr_imm);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    inst_addr   = '0;
    inst_data   = 32'h00000013;
    rs1_data    = '0;
    rs2_data    = '0;
    ex_rd_data  = '0;
    mem_rd_addr = '0;
    mem_rd_data = '0;
    fill_vectors();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    expect_bubble();
    compare_value("load_use_o", load_use, 1'b0);
    pc = 64'h0000_0000_8000_0000;
    for (int i = 0; i < NUM_VEC; i++) begin
      rs1_data    = {$random(seed), $random(seed)};
      rs2_data    = {$random(seed), $random(seed)};
      ex_rd_data  = {$random(seed), $random(seed)};
      mem_rd_data = {$random(seed), $random(seed)};
      mem_rd_addr = vec[i].mem_rd;
      inst_addr   = pc;
      inst_data   = vec[i].inst;
      exp_rs1 = pick_operand(vec[i].src1, rs1_data, ex_rd_data, mem_rd_data);
      exp_rs2 = pick_operand(vec[i].src2, rs2_data, ex_rd_data, mem_rd_data);
      #1;
      compare_value("load_use_o", load_use, vec[i].load_use);
      compare_value("rs1_idx_o", rs1_idx, vec[i].rs1);
      compare_value("rs2_idx_o", rs2_idx, vec[i].rs2);
      @(negedge clk);
      verify_row(i, pc, exp_rs1, exp_rs2);
      // fetch repeats the same pc after a stall
      if (!vec[i].load_use) begin
        pc = pc + 64'd4;
      end
    end
    $display("TB PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the vector table did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* flist.f */
+incdir+bench
source/rv_decode_pkg.sv
source/inst_decoder.sv
source/imm_gen.sv
source/operand_forward.sv
source/id_ex_reg.sv
source/decode_stage.sv
bench/tb_decode_stage.sv

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  rv_decode_pkg::xlen_t                inst_addr_i,
  input  logic [rv_decode_pkg::INST_W-1:0]    inst_data_i,
  input  rv_decode_pkg::xlen_t                rs1_data_i,
  input  rv_decode_pkg::xlen_t                rs2_data_i,
  input  rv_decode_pkg::xlen_t                ex_rd_data_i,
  input  rv_decode_pkg::reg_idx_t             mem_rd_addr_i,
  input  rv_decode_pkg::xlen_t                mem_rd_data_i,
  output rv_decode_pkg::reg_idx_t             rs1_idx_o,
  output rv_decode_pkg::reg_idx_t             rs2_idx_o,
  output logic                                load_use_o,
  output rv_decode_pkg::xlen_t                ex_inst_addr_o,
  output rv_decode_pkg::xlen_t                ex_rs1_data_o,
  output rv_decode_pkg::xlen_t                ex_rs2_data_o,
  output rv_decode_pkg::reg_idx_t             ex_rd_idx_o,
  output rv_decode_pkg::xlen_t                ex_imm_o,
  output rv_decode_pkg::csr_idx_t             ex_csr_idx_o,
  output logic [rv_decode_pkg::CSR_IMM_W-1:0] ex_csr_imm_o,
  output logic                                ex_csr_imm_valid_o,
  output rv_decode_pkg::alu_op_e              ex_alu_op_o,
  output rv_decode_pkg::exc_op_e              ex_exc_op_o,
  output rv_decode_pkg::mem_op_e              ex_mem_op_o,
  output rv_decode_pkg::csr_op_e              ex_csr_op_o,
  output logic [rv_decode_pkg::TRAP_W-1:0]    ex_trap_o
);
  import rv_decode_pkg::*;

  reg_idx_t                 rd_idx;
  csr_idx_t                 csr_idx;
  logic [CSR_IMM_W-1:0]     csr_imm;
  logic                     csr_imm_valid;
  imm_fmt_e                 imm_fmt;
  alu_op_e                  alu_op;
  exc_op_e                  exc_op;
  mem_op_e                  mem_op;
  csr_op_e                  csr_op;
  logic [TRAP_W-1:0]        trap;
  xlen_t                    imm;
  reg_idx_t [NUM_SRC-1:0]   src_idx;
  xlen_t [NUM_SRC-1:0]      rf_data;
  xlen_t [NUM_SRC-1:0]      fwd_data;
  logic [NUM_SRC-1:0]       ex_hit;

  inst_decoder u_inst_decoder (
    .inst_i          (inst_data_i),
    .rs1_idx_o       (rs1_idx_o),
    .rs2_idx_o       (rs2_idx_o),
    .rd_idx_o        (rd_idx),
    .csr_idx_o       (csr_idx),
    .csr_imm_o       (csr_imm),
    .csr_imm_valid_o (csr_imm_valid),
    .imm_fmt_o       (imm_fmt),
    .alu_op_o        (alu_op),
    .exc_op_o        (exc_op),
    .mem_op_o        (mem_op),
    .csr_op_o        (csr_op),
    .trap_o          (trap)
  );

  imm_gen u_imm_gen (
    .inst_i    (inst_data_i),
    .imm_fmt_i (imm_fmt),
    .imm_o     (imm)
  );

  // source 0 is rs1, source 1 is rs2
  assign src_idx = {rs2_idx_o, rs1_idx_o};
  assign rf_data = {rs2_data_i, rs1_data_i};

  for (genvar k = 0; k < NUM_SRC; k++) begin : g_fwd
    operand_forward u_operand_forward (
      .rs_idx_i      (src_idx[k]),
      .rf_data_i     (rf_data[k]),
      .ex_rd_idx_i   (ex_rd_idx_o),
      .ex_rd_data_i  (ex_rd_data_i),
      .mem_rd_idx_i  (mem_rd_addr_i),
      .mem_rd_data_i (mem_rd_data_i),
      .rs_data_o     (fwd_data[k]),
      .ex_hit_o      (ex_hit[k])
    );
  end

  id_ex_reg u_id_ex_reg (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .ex_hit_i           (ex_hit),
    .inst_addr_i        (inst_addr_i),
    .rs1_data_i         (fwd_data[0]),
    .rs2_data_i         (fwd_data[1]),
    .rd_idx_i           (rd_idx),
    .imm_i              (imm),
    .csr_idx_i          (csr_idx),
    .csr_imm_i          (csr_imm),
    .csr_imm_valid_i    (csr_imm_valid),
    .alu_op_i           (alu_op),
    .exc_op_i           (exc_op),
    .mem_op_i           (mem_op),
    .csr_op_i           (csr_op),
    .trap_i             (trap),
    .load_use_o         (load_use_o),
    .ex_inst_addr_o     (ex_inst_addr_o),
    .ex_rs1_data_o      (ex_rs1_data_o),
    .ex_rs2_data_o      (ex_rs2_data_o),
    .ex_rd_idx_o        (ex_rd_idx_o),
    .ex_imm_o           (ex_imm_o),
    .ex_csr_idx_o       (ex_csr_idx_o),
    .ex_csr_imm_o       (ex_csr_imm_o),
    .ex_csr_imm_valid_o (ex_csr_imm_valid_o),
    .ex_alu_op_o        (ex_alu_op_o),
    .ex_exc_op_o        (ex_exc_op_o),
    .ex_mem_op_o        (ex_mem_op_o),
    .ex_csr_op_o        (ex_csr_op_o),
    .ex_trap_o          (ex_trap_o)
  );

endmodule

/* source/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [rv_decode_pkg::NUM_SRC-1:0]   ex_hit_i,
  input  rv_decode_pkg::xlen_t                inst_addr_i,
  input  rv_decode_pkg::xlen_t                rs1_data_i,
  input  rv_decode_pkg::xlen_t                rs2_data_i,
  input  rv_decode_pkg::reg_idx_t             rd_idx_i,
  input  rv_decode_pkg::xlen_t                imm_i,
  input  rv_decode_pkg::csr_idx_t             csr_idx_i,
  input  logic [rv_decode_pkg::CSR_IMM_W-1:0] csr_imm_i,
  input  logic                                csr_imm_valid_i,
  input  rv_decode_pkg::alu_op_e              alu_op_i,
  input  rv_decode_pkg::exc_op_e              exc_op_i,
  input  rv_decode_pkg::mem_op_e              mem_op_i,
  input  rv_decode_pkg::csr_op_e              csr_op_i,
  input  logic [rv_decode_pkg::TRAP_W-1:0]    trap_i,
  output logic                                load_use_o,
  output rv_decode_pkg::xlen_t                ex_inst_addr_o,
  output rv_decode_pkg::xlen_t                ex_rs1_data_o,
  output rv_decode_pkg::xlen_t                ex_rs2_data_o,
  output rv_decode_pkg::reg_idx_t             ex_rd_idx_o,
  output rv_decode_pkg::xlen_t                ex_imm_o,
  output rv_decode_pkg::csr_idx_t             ex_csr_idx_o,
  output logic [rv_decode_pkg::CSR_IMM_W-1:0] ex_csr_imm_o,
  output logic                                ex_csr_imm_valid_o,
  output rv_decode_pkg::alu_op_e              ex_alu_op_o,
  output rv_decode_pkg::exc_op_e              ex_exc_op_o,
  output rv_decode_pkg::mem_op_e              ex_mem_op_o,
  output rv_decode_pkg::csr_op_e              ex_csr_op_o,
  output logic [rv_decode_pkg::TRAP_W-1:0]    ex_trap_o
);
  import rv_decode_pkg::*;

  // load data is not ready until MEM, so a dependent instruction waits a cycle
  assign load_use_o = (ex_exc_op_o == EXC_LOAD) && (|ex_hit_i);

  // control fields, cleared to a bubble on reset or stall
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || load_use_o) begin
      ex_rd_idx_o        <= BUBBLE_RD;
      ex_csr_imm_valid_o <= 1'b0;
      ex_alu_op_o        <= ALU_NOP;
      ex_exc_op_o        <= BUBBLE_EXC;
      ex_mem_op_o        <= MEM_NOP;
      ex_csr_op_o        <= CSR_NOP;
      ex_trap_o          <= BUBBLE_TRAP;
    end else begin
      ex_rd_idx_o        <= rd_idx_i;
      ex_csr_imm_valid_o <= csr_imm_valid_i;
      ex_alu_op_o        <= alu_op_i;
      ex_exc_op_o        <= exc_op_i;
      ex_mem_op_o        <= mem_op_i;
      ex_csr_op_o        <= csr_op_i;
      ex_trap_o          <= trap_i;
    end
  end

  // payload, meaningless while the control fields hold a bubble
  always_ff @(posedge clk_i) begin
    ex_inst_addr_o <= inst_addr_i;
    ex_rs1_data_o  <= rs1_data_i;
    ex_rs2_data_o  <= rs2_data_i;
    ex_imm_o       <= imm_i;
    ex_csr_idx_o   <= csr_idx_i;
    ex_csr_imm_o   <= csr_imm_i;
  end

endmodule

/* source/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
  input  logic [rv_decode_pkg::INST_W-1:0] inst_i,
  input  rv_decode_pkg::imm_fmt_e          imm_fmt_i,
  output rv_decode_pkg::xlen_t             imm_o
);
  import rv_decode_pkg::*;

  logic sign;

  assign sign = inst_i[31];

  always_comb begin
    unique case (imm_fmt_i)
      IMM_I: imm_o = {{(XLEN-11){sign}}, inst_i[30:20]};
      IMM_S: imm_o = {{(XLEN-11){sign}}, inst_i[30:25], inst_i[11:7]};
      IMM_B: begin
        imm_o = {{(XLEN-12){sign}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
      end
      // upper immediate fills bits 31:12, sign taken from bit 31
      IMM_U: imm_o = {{(XLEN-31){sign}}, inst_i[30:12], 12'b0};
      IMM_J: begin
        imm_o = {{(XLEN-20){sign}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
      end
      default: imm_o = '0;
    endcase
  end

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic [rv_decode_pkg::INST_W-1:0]    inst_i,
  output rv_decode_pkg::reg_idx_t             rs1_idx_o,
  output rv_decode_pkg::reg_idx_t             rs2_idx_o,
  output rv_decode_pkg::reg_idx_t             rd_idx_o,
  output rv_decode_pkg::csr_idx_t             csr_idx_o,
  output logic [rv_decode_pkg::CSR_IMM_W-1:0] csr_imm_o,
  output logic                                csr_imm_valid_o,
  output rv_decode_pkg::imm_fmt_e             imm_fmt_o,
  output rv_decode_pkg::alu_op_e              alu_op_o,
  output rv_decode_pkg::exc_op_e              exc_op_o,
  output rv_decode_pkg::mem_op_e              mem_op_o,
  output rv_decode_pkg::csr_op_e              csr_op_o,
  output logic [rv_decode_pkg::TRAP_W-1:0]    trap_o
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       use_rs1;
  logic       use_rs2;
  logic       use_rd;
  logic       is_csr;
  logic       illegal;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  always_comb begin
    alu_op_o  = ALU_NOP;
    exc_op_o  = EXC_NONE;
    mem_op_o  = MEM_NOP;
    csr_op_o  = CSR_NOP;
    imm_fmt_o = IMM_NONE;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    use_rd    = 1'b0;
    is_csr    = 1'b0;
    illegal   = 1'b0;
    trap_o    = '0;
    unique case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        exc_op_o  = (opcode == OPC_LUI) ? EXC_LUI : EXC_AUIPC;
        alu_op_o  = ALU_ADD;
        imm_fmt_o = IMM_U;
        use_rd    = 1'b1;
      end
      OPC_JAL: begin
        exc_op_o  = EXC_JAL;
        alu_op_o  = ALU_ADD;
        imm_fmt_o = IMM_J;
        use_rd    = 1'b1;
      end
      OPC_JALR: begin
        exc_op_o  = EXC_JALR;
        alu_op_o  = ALU_ADD;
        imm_fmt_o = IMM_I;
        {use_rs1, use_rd} = 2'b11;
        illegal   = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        exc_op_o  = EXC_BRANCH;
        imm_fmt_o = IMM_B;
        {use_rs1, use_rs2} = 2'b11;
        case (funct3)
          3'b000:  alu_op_o = ALU_BEQ;
          3'b001:  alu_op_o = ALU_BNE;
          3'b100:  alu_op_o = ALU_BLT;
          3'b101:  alu_op_o = ALU_BGE;
          3'b110:  alu_op_o = ALU_BLTU;
          3'b111:  alu_op_o = ALU_BGEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        exc_op_o  = EXC_LOAD;
        alu_op_o  = ALU_ADD;
        imm_fmt_o = IMM_I;
        {use_rs1, use_rd} = 2'b11;
        case (funct3)
          3'b000:  mem_op_o = MEM_LB;
          3'b001:  mem_op_o = MEM_LH;
          3'b010:  mem_op_o = MEM_LW;
          3'b011:  mem_op_o = MEM_LD;
          3'b100:  mem_op_o = MEM_LBU;
          3'b101:  mem_op_o = MEM_LHU;
          3'b110:  mem_op_o = MEM_LWU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_STORE: begin
        exc_op_o  = EXC_STORE;
        alu_op_o  = ALU_ADD;
        imm_fmt_o = IMM_S;
        {use_rs1, use_rs2} = 2'b11;
        case (funct3)
          3'b000:  mem_op_o = MEM_SB;
          3'b001:  mem_op_o = MEM_SH;
          3'b010:  mem_op_o = MEM_SW;
          3'b011:  mem_op_o = MEM_SD;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        exc_op_o  = EXC_OPIMM;
        imm_fmt_o = IMM_I;
        {use_rs1, use_rd} = 2'b11;
        // rv64 shift amounts are six bits, so only funct7[6:1] selects the shift
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b001: begin
            alu_op_o = ALU_SLL;
            illegal  = (funct7[6:1] != 6'b000000);
          end
          default: begin
            alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal  = ({funct7[6], funct7[4:1]} != 5'b00000);
          end
        endcase
      end
      OPC_OP_IMM32: begin
        exc_op_o  = EXC_OPIMM32;
        imm_fmt_o = IMM_I;
        {use_rs1, use_rd} = 2'b11;
        casez ({funct7, funct3})
          {7'b???????, 3'b000}: alu_op_o = ALU_ADD;
          {7'b0000000, 3'b001}: alu_op_o = ALU_SLLW;
          {7'b0000000, 3'b101}: alu_op_o = ALU_SRLW;
          {7'b0100000, 3'b101}: alu_op_o = ALU_SRAW;
          default:              illegal = 1'b1;
        endcase
      end
      OPC_OP: begin
        exc_op_o = EXC_OP;
        {use_rs1, use_rs2, use_rd} = 3'b111;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
          {7'b0000000, 3'b001}: alu_op_o = ALU_SLL;
          {7'b0000000, 3'b010}: alu_op_o = ALU_SLT;
          {7'b0000000, 3'b011}: alu_op_o = ALU_SLTU;
          {7'b0000000, 3'b100}: alu_op_o = ALU_XOR;
          {7'b0000000, 3'b101}: alu_op_o = ALU_SRL;
          {7'b0100000, 3'b101}: alu_op_o = ALU_SRA;
          {7'b0000000, 3'b110}: alu_op_o = ALU_OR;
          {7'b0000000, 3'b111}: alu_op_o = ALU_AND;
          {7'b0000001, 3'b000}: alu_op_o = ALU_MUL;
          {7'b0000001, 3'b001}: alu_op_o = ALU_MULH;
          {7'b0000001, 3'b010}: alu_op_o = ALU_MULHSU;
          {7'b0000001, 3'b011}: alu_op_o = ALU_MULHU;
          {7'b0000001, 3'b100}: alu_op_o = ALU_DIV;
          {7'b0000001, 3'b101}: alu_op_o = ALU_DIVU;
          {7'b0000001, 3'b110}: alu_op_o = ALU_REM;
          {7'b0000001, 3'b111}: alu_op_o = ALU_REMU;
          default:              illegal = 1'b1;
        endcase
      end
      OPC_OP32: begin
        exc_op_o = EXC_OP32;
        {use_rs1, use_rs2, use_rd} = 3'b111;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
          {7'b0000000, 3'b001}: alu_op_o = ALU_SLLW;
          {7'b0000000, 3'b101}: alu_op_o = ALU_SRLW;
          {7'b0100000, 3'b101}: alu_op_o = ALU_SRAW;
          {7'b0000001, 3'b000}: alu_op_o = ALU_MULW;
          {7'b0000001, 3'b100}: alu_op_o = ALU_DIVW;
          {7'b0000001, 3'b101}: alu_op_o = ALU_DIVUW;
          {7'b0000001, 3'b110}: alu_op_o = ALU_REMW;
          {7'b0000001, 3'b111}: alu_op_o = ALU_REMUW;
          default:              illegal = 1'b1;
        endcase
      end
      OPC_MISC_MEM: begin
        // fence is a no-op here and fence.i goes to memory
        exc_op_o = EXC_BUBBLE;
        mem_op_o = (funct3 == 3'b001) ? MEM_FENCEI : MEM_NOP;
        illegal  = (funct3[2:1] != 2'b00);
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          exc_op_o = EXC_BUBBLE;
          case (inst_i[31:20])
            12'h000: trap_o[TRAP_ECALL] = 1'b1;
            12'h001: begin
              trap_o[TRAP_EBREAK] = 1'b1;
              exc_op_o            = EXC_EBREAK;
            end
            12'h302: trap_o[TRAP_MRET] = 1'b1;
            default: illegal = 1'b1;
          endcase
        end else begin
          exc_op_o  = EXC_CSR;
          alu_op_o  = ALU_ADD;
          imm_fmt_o = IMM_I;
          is_csr    = 1'b1;
          use_rd    = 1'b1;
          // immediate forms carry uimm where rs1 would be
          use_rs1   = ~funct3[2];
          illegal   = (funct3[1:0] == 2'b00);
          if (funct3[1] && (inst_i[19:15] == 5'd0)) begin
            csr_op_o = CSR_READ;
          end else begin
            case (funct3[1:0])
              2'b01:   csr_op_o = CSR_WRITE;
              2'b10:   csr_op_o = CSR_SET;
              default: csr_op_o = CSR_CLEAR;
            endcase
          end
        end
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      exc_op_o = EXC_NONE;
    end
    trap_o[TRAP_ILLEGAL] = illegal;
  end

  assign rs1_idx_o       = use_rs1 ? inst_i[19:15] : '0;
  assign rs2_idx_o       = use_rs2 ? inst_i[24:20] : '0;
  assign rd_idx_o        = use_rd ? inst_i[11:7] : '0;
  assign csr_idx_o       = is_csr ? inst_i[31:20] : '0;
  assign csr_imm_valid_o = is_csr & funct3[2];
  assign csr_imm_o       = csr_imm_valid_o ? inst_i[19:15] : '0;

endmodule

/* source/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
  input  rv_decode_pkg::reg_idx_t rs_idx_i,
  input  rv_decode_pkg::xlen_t    rf_data_i,
  input  rv_decode_pkg::reg_idx_t ex_rd_idx_i,
  input  rv_decode_pkg::xlen_t    ex_rd_data_i,
  input  rv_decode_pkg::reg_idx_t mem_rd_idx_i,
  input  rv_decode_pkg::xlen_t    mem_rd_data_i,
  output rv_decode_pkg::xlen_t    rs_data_o,
  output logic                    ex_hit_o
);

  logic rs_valid;
  logic mem_hit;

  // x0 reads as zero from the register file and is never bypassed
  assign rs_valid = (rs_idx_i != '0);
  assign ex_hit_o = rs_valid && (rs_idx_i == ex_rd_idx_i);
  assign mem_hit  = rs_valid && (rs_idx_i == mem_rd_idx_i);

  // youngest result first
  assign rs_data_o = ex_hit_o ? ex_rd_data_i :
                     mem_hit  ? mem_rd_data_i :
                                rf_data_i;

endmodule

/* source/rv_decode_pkg.sv */
package rv_decode_pkg;

  localparam int XLEN      = 64;
  localparam int INST_W    = 32;
  localparam int REG_AW    = 5;
  localparam int CSR_AW    = 12;
  localparam int CSR_IMM_W = 5;
  localparam int TRAP_W    = 4;
  // rs1 and rs2
  localparam int NUM_SRC   = 2;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [REG_AW-1:0] reg_idx_t;
  typedef logic [CSR_AW-1:0] csr_idx_t;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_fmt_e;

  // word variants of add and sub share ADD and SUB, execute sign-extends by class
  typedef enum logic [5:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW, ALU_SRLW, ALU_SRAW,
    ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, ALU_MULW,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU, ALU_DIVW, ALU_DIVUW, ALU_REMW, ALU_REMUW
  } alu_op_e;

  typedef enum logic [3:0] {
    EXC_BUBBLE, EXC_AUIPC, EXC_LUI, EXC_JAL, EXC_JALR, EXC_LOAD, EXC_STORE,
    EXC_BRANCH, EXC_OPIMM, EXC_OPIMM32, EXC_OP, EXC_OP32, EXC_CSR, EXC_EBREAK,
    EXC_NONE
  } exc_op_e;

  typedef enum logic [3:0] {
    MEM_NOP, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWU, MEM_LD,
    MEM_SB, MEM_SH, MEM_SW, MEM_SD, MEM_FENCEI
  } mem_op_e;

  typedef enum logic [2:0] {
    CSR_NOP, CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR
  } csr_op_e;

  // trap vector bit positions
  localparam int TRAP_ECALL   = 0;
  localparam int TRAP_EBREAK  = 1;
  localparam int TRAP_MRET    = 2;
  localparam int TRAP_ILLEGAL = 3;

  // major opcodes of the base map
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_OP32     = 7'b0111011;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // contents of an empty ID/EX slot
  localparam exc_op_e              BUBBLE_EXC  = EXC_BUBBLE;
  localparam logic [TRAP_W-1:0]    BUBBLE_TRAP = '0;
  localparam reg_idx_t             BUBBLE_RD   = '0;

endpackage
